/* buffer_pkg.sv */
package buffer_pkg;

  // lanes per RAM word
  localparam int LOG_E = 2;
  localparam int E = 1 << LOG_E;

  // coefficient width in bits
  localparam int FSIZE = 8;

  // total coefficient count is 2^LOG_N
  localparam int LOG_N = 8;

  // word address and the field left once a lane-sized field is removed
  localparam int ADDR_W = LOG_N - LOG_E;
  localparam int MID_W = ADDR_W - LOG_E;
  localparam int WORDS = 1 << ADDR_W;

  typedef logic [ADDR_W-1:0] addr_t;

  // lane index, also the position of a word inside a block
  typedef logic [LOG_E-1:0] lane_idx_t;

  // one RAM word, flat for storage or split into lanes for the transposer
  typedef union packed {
    logic [E*FSIZE-1:0] flat;
    logic [E-1:0][FSIZE-1:0] lanes;
  } ram_word_u;

endpackage

/* perm_pkg.sv */
package perm_pkg;
  import buffer_pkg::*;

  // width of the transpose base field select
  localparam int BASE_W = 3;

  typedef enum logic {
    MODE_BITREV = 1'b0,
    MODE_TRANSPOSE = 1'b1
  } perm_mode_e;

  function automatic lane_idx_t bit_reverse_lane(input lane_idx_t v);
    lane_idx_t r;
    for (int b = 0; b < LOG_E; b++) begin
      r[LOG_E-1-b] = v[b];
    end
    return r;
  endfunction

  function automatic logic [MID_W-1:0] bit_reverse_mid(input logic [MID_W-1:0] v);
    logic [MID_W-1:0] r;
    for (int b = 0; b < MID_W; b++) begin
      r[MID_W-1-b] = v[b];
    end
    return r;
  endfunction

  // low bits of rest stay below base, the rest moves up above the field
  function automatic addr_t insert_field(input lane_idx_t field,
                                         input logic [BASE_W-1:0] base,
                                         input logic [MID_W-1:0] rest);
    addr_t low_mask;
    addr_t wide;
    low_mask = addr_t'((1 << base) - 1);
    wide = addr_t'(rest);
    return ((wide & ~low_mask) << LOG_E) | (addr_t'(field) << base) | (wide & low_mask);
  endfunction

endpackage

/* ram_if.sv */
`timescale 1ns/10ps

interface ram_if;
  import buffer_pkg::*;

  addr_t raddr;
  ram_word_u rdata;
  addr_t waddr;
  ram_word_u wdata;
  logic wren;

  // buffer side
  modport ram (input raddr, input waddr, input wdata, input wren, output rdata);

  // read side of the engine
  modport load (output raddr, input rdata);

  // write side of the engine
  modport store (output waddr, output wdata, output wren);

endinterface

/* beat_if.sv */
`timescale 1ns/10ps

interface beat_if;
  import buffer_pkg::*;

  ram_word_u data;
  logic valid;
  logic last;
  // block number of the word being emitted
  addr_t tag;

  modport src (output data, output valid, output last, output tag);

  modport dst (input data, input valid, input last, input tag);

endinterface

/* buffer_ram.sv */
`timescale 1ns/10ps

module buffer_ram (
  input logic clk,
  input logic host_we,
  input buffer_pkg::addr_t host_addr,
  input buffer_pkg::ram_word_u host_wdata,
  output buffer_pkg::ram_word_u host_rdata,
  ram_if.ram eng
);
  import buffer_pkg::*;

  logic [E*FSIZE-1:0] mem [WORDS];

  // single write port, engine has priority over host
  always_ff @(posedge clk) begin
    if (eng.wren) begin
      mem[eng.waddr] <= eng.wdata.flat;
    end else if (host_we) begin
      mem[host_addr] <= host_wdata.flat;
    end
  end

  // registered reads, old contents win on a same-cycle write
  always_ff @(posedge clk) begin
    eng.rdata.flat <= mem[eng.raddr];
  end

  always_ff @(posedge clk) begin
    host_rdata.flat <= mem[host_addr];
  end

endmodule

/* load_sequencer.sv */
`timescale 1ns/10ps

module load_sequencer (
  input logic clk,
  input logic rstn,
  input logic start_bitrev,
  input logic start_transpose,
  input logic [perm_pkg::BASE_W-1:0] transpose_base,
  ram_if.load ram,
  output logic in_valid,
  output logic in_last,
  output buffer_pkg::addr_t in_tag
);
  import buffer_pkg::*;
  import perm_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BITREV,
    ST_TRANSPOSE,
    ST_DRAIN
  } state_e;

  localparam logic [MID_W-1:0] LAST_BLK = '1;

  state_e state;
  lane_idx_t k;
  logic [MID_W-1:0] blk;
  logic on_pair;
  logic [BASE_W-1:0] base_q;
  logic [LOG_E:0] drain_cnt;

  logic [MID_W-1:0] blk_rev;
  logic [MID_W-1:0] cur_blk;
  logic skip;
  logic issue;
  logic blk_end;
  logic issue_last;
  addr_t issue_tag;

  always_comb begin
    blk_rev = bit_reverse_mid(blk);
    // second half of a pair reads the mirrored block
    cur_blk = on_pair ? blk_rev : blk;
    // already handled as the partner of a smaller block
    skip = (state == ST_BITREV) && !on_pair && (blk > blk_rev);
    issue = ((state == ST_BITREV) && !skip) || (state == ST_TRANSPOSE);
    blk_end = issue && (k == lane_idx_t'(E - 1));
    issue_last = blk_end && !on_pair && (blk == LAST_BLK);
    if (state == ST_TRANSPOSE) begin
      ram.raddr = insert_field(k, base_q, blk);
      issue_tag = addr_t'(blk);
    end else begin
      ram.raddr = {bit_reverse_lane(k), cur_blk};
      issue_tag = addr_t'(bit_reverse_mid(cur_blk));
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= ST_IDLE;
      k <= '0;
      blk <= '0;
      on_pair <= 1'b0;
      drain_cnt <= '0;
      in_valid <= 1'b0;
      in_last <= 1'b0;
    end else begin
      // valid and last follow the one-cycle RAM read
      in_valid <= issue;
      in_last <= issue_last;
      case (state)
        ST_IDLE: begin
          k <= '0;
          blk <= '0;
          on_pair <= 1'b0;
          if (start_bitrev) begin
            state <= ST_BITREV;
          end else if (start_transpose) begin
            state <= ST_TRANSPOSE;
          end
        end
        ST_BITREV, ST_TRANSPOSE: begin
          if (skip) begin
            blk <= blk + 1'b1;
          end else begin
            k <= k + 1'b1;
            if (blk_end) begin
              if (issue_last) begin
                state <= ST_DRAIN;
                drain_cnt <= '0;
              end else if (on_pair) begin
                on_pair <= 1'b0;
                blk <= blk + 1'b1;
              end else if ((state == ST_BITREV) && (blk_rev != blk)) begin
                on_pair <= 1'b1;
              end else begin
                blk <= blk + 1'b1;
              end
            end
          end
        end
        ST_DRAIN: begin
          // hold off new starts until the store side has written its last beat
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == (LOG_E + 1)'(E)) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    in_tag <= issue_tag;
    if (state == ST_IDLE) begin
      base_q <= transpose_base;
    end
  end

endmodule

/* transposer.sv */
`timescale 1ns/10ps

module transposer (
  input logic clk,
  input logic rstn,
  input buffer_pkg::ram_word_u in_data,
  input logic in_valid,
  input logic in_last,
  input buffer_pkg::addr_t in_tag,
  beat_if.src out
);
  import buffer_pkg::*;

  // two banks of E rows, one loading while the other empties
  ram_word_u bank [2][E];

  lane_idx_t in_row;
  logic load_sel;
  logic emit_on;
  lane_idx_t emit_col;
  logic final_blk;
  addr_t emit_tag;
  logic blk_done;

  assign blk_done = in_valid && (in_row == lane_idx_t'(E - 1));

  always_ff @(posedge clk) begin
    if (in_valid) begin
      bank[load_sel][in_row] <= in_data;
    end
    if (blk_done) begin
      emit_tag <= in_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      in_row <= '0;
      load_sel <= 1'b0;
      emit_on <= 1'b0;
      emit_col <= '0;
      final_blk <= 1'b0;
    end else begin
      if (in_valid) begin
        in_row <= in_row + 1'b1;
      end
      if (emit_on) begin
        emit_col <= emit_col + 1'b1;
        if (emit_col == lane_idx_t'(E - 1)) begin
          emit_on <= 1'b0;
        end
      end
      // a full bank starts emitting on the next cycle
      if (blk_done) begin
        load_sel <= ~load_sel;
        emit_on <= 1'b1;
        emit_col <= '0;
        final_blk <= in_last;
      end
    end
  end

  // column emit_col of the full bank, lane k from row k
  always_comb begin
    for (int k = 0; k < E; k++) begin
      out.data.lanes[k] = bank[~load_sel][k].lanes[emit_col];
    end
  end

  assign out.valid = emit_on;
  assign out.last = emit_on && final_blk && (emit_col == lane_idx_t'(E - 1));
  assign out.tag = emit_tag;

endmodule

/* store_sequencer.sv */
`timescale 1ns/10ps

module store_sequencer (
  input logic clk,
  input logic rstn,
  input logic start_bitrev,
  input logic start_transpose,
  input logic [perm_pkg::BASE_W-1:0] transpose_base,
  beat_if.dst beat,
  ram_if.store ram,
  output logic busy
);
  import buffer_pkg::*;
  import perm_pkg::*;

  perm_mode_e mode;
  logic [BASE_W-1:0] base_q;
  lane_idx_t j;
  logic [MID_W-1:0] blk;

  // block number carried alongside the data
  assign blk = beat.tag[MID_W-1:0];

  always_comb begin
    if (mode == MODE_TRANSPOSE) begin
      ram.waddr = insert_field(j, base_q, blk);
    end else begin
      ram.waddr = {bit_reverse_lane(j), blk};
    end
  end

  // every beat is written in the cycle it arrives
  assign ram.wdata = beat.data;
  assign ram.wren = beat.valid;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy <= 1'b0;
      mode <= MODE_BITREV;
      j <= '0;
    end else if (!busy) begin
      j <= '0;
      if (start_bitrev) begin
        busy <= 1'b1;
        mode <= MODE_BITREV;
      end else if (start_transpose) begin
        busy <= 1'b1;
        mode <= MODE_TRANSPOSE;
      end
    end else if (beat.valid) begin
      j <= j + 1'b1;
      if (beat.last) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy) begin
      base_q <= transpose_base;
    end
  end

endmodule

/* bitrev_transpose_top.sv */
`timescale 1ns/10ps

module bitrev_transpose_top (
  input logic clk,
  input logic rstn,
  input logic host_we,
  input buffer_pkg::addr_t host_addr,
  input buffer_pkg::ram_word_u host_wdata,
  output buffer_pkg::ram_word_u host_rdata,
  input logic start_bitrev,
  input logic start_transpose,
  input logic [perm_pkg::BASE_W-1:0] transpose_base,
  output logic busy
);

  ram_if ram_bus ();
  beat_if beat_bus ();

  // read side to transposer
  logic in_valid;
  logic in_last;
  buffer_pkg::addr_t in_tag;

  buffer_ram u_ram (
    .clk        (clk),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .eng        (ram_bus.ram)
  );

  load_sequencer u_load (
    .clk             (clk),
    .rstn            (rstn),
    .start_bitrev    (start_bitrev),
    .start_transpose (start_transpose),
    .transpose_base  (transpose_base),
    .ram             (ram_bus.load),
    .in_valid        (in_valid),
    .in_last         (in_last),
    .in_tag          (in_tag)
  );

  transposer u_tr (
    .clk      (clk),
    .rstn     (rstn),
    .in_data  (ram_bus.rdata),
    .in_valid (in_valid),
    .in_last  (in_last),
    .in_tag   (in_tag),
    .out      (beat_bus.src)
  );

  store_sequencer u_store (
    .clk             (clk),
    .rstn            (rstn),
    .start_bitrev    (start_bitrev),
    .start_transpose (start_transpose),
    .transpose_base  (transpose_base),
    .beat            (beat_bus.dst),
    .ram             (ram_bus.store),
    .busy            (busy)
  );

endmodule

/* tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk,
  output logic rstn
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held low over the first two rising edges
  initial begin
    rstn = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
  end

endmodule

/* tb_top.sv */
`timescale 1ns/10ps

module tb_top;
  import buffer_pkg::*;

  localparam int N = 1 << LOG_N;
  localparam int NWORDS = N / E;
  // nine host loads and readbacks of 128 cycles and nine operations under 100 cycles
  localparam int MAX_CYCLES = 4000;
  localparam int BUSY_LIMIT = 400;

  logic clk;
  logic rstn;
  logic host_we;
  addr_t host_addr;
  ram_word_u host_wdata;
  ram_word_u host_rdata;
  logic start_bitrev;
  logic start_transpose;
  logic [2:0] transpose_base;
  logic busy;

  logic [31:0] rng_state;
  int cycles = 0;
  logic [FSIZE-1:0] orig [N];
  logic [FSIZE-1:0] expect_mem [N];

  tb_clkgen u_clk (
    .clk  (clk),
    .rstn (rstn)
  );

  bitrev_transpose_top dut0 (
    .clk             (clk),
    .rstn            (rstn),
    .host_we         (host_we),
    .host_addr       (host_addr),
    .host_wdata      (host_wdata),
    .host_rdata      (host_rdata),
    .start_bitrev    (start_bitrev),
    .start_transpose (start_transpose),
    .transpose_base  (transpose_base),
    .busy            (busy)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int reverse_bits(input int v, input int width);
    int r;
    r = 0;
    for (int b = 0; b < width; b++) begin
      if (v[b]) begin
        r |= 1 << (width - 1 - b);
      end
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < N; i++) begin
      rng_state = lcg_step(rng_state);
      orig[i] = rng_state[23:16];
    end
  endtask

  // coefficient i sits in word i / E at lane i % E
  task automatic write_words();
    for (int a = 0; a < NWORDS; a++) begin
      host_we = 1'b1;
      host_addr = addr_t'(a);
      for (int l = 0; l < E; l++) begin
        host_wdata.lanes[l] = orig[a*E + l];
      end
      @(posedge clk);
      #1;
    end
    host_we = 1'b0;
  endtask

  task automatic read_and_check(input string what);
    for (int a = 0; a < NWORDS; a++) begin
      host_addr = addr_t'(a);
      @(posedge clk);
      #1;
      // step the address so only a one-cycle registered read still shows word a
      host_addr = addr_t'(a + 1);
      for (int l = 0; l < E; l++) begin
        check_value($sformatf("%s host_rdata word %0d lane %0d", what, a, l),
                    32'(expect_mem[a*E + l]), 32'(host_rdata.lanes[l]));
      end
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (busy === 1'b1) begin
      if (waited >= BUSY_LIMIT) begin
        $display("busy did not fall within %0d cycles", BUSY_LIMIT);
        $display("** FAIL **");
        $fatal(1, "operation did not finish");
      end else begin
        @(posedge clk);
        #1;
        waited++;
      end
    end
  endtask

  task automatic run_op(input logic bitrev, input logic [2:0] base);
    check_value("busy", 32'(1'b0), 32'(busy));
    start_bitrev = bitrev;
    start_transpose = !bitrev;
    transpose_base = base;
    @(posedge clk);
    #1;
    start_bitrev = 1'b0;
    start_transpose = 1'b0;
    check_value("busy", 32'(1'b1), 32'(busy));
    wait_idle();
  endtask

  task automatic bitrev_model();
    for (int i = 0; i < N; i++) begin
      expect_mem[i] = orig[reverse_bits(i, LOG_N)];
    end
  endtask

  // field f at base swaps with the lane
  task automatic transpose_model(input int base);
    int f;
    int src;
    for (int a = 0; a < NWORDS; a++) begin
      for (int l = 0; l < E; l++) begin
        f = (a >> base) & (E - 1);
        src = (a & ~((E - 1) << base)) | (l << base);
        expect_mem[a*E + l] = orig[src*E + f];
      end
    end
  endtask

  task automatic host_write_readback();
    check_value("busy after reset", 32'(1'b0), 32'(busy));
    fill_random();
    expect_mem = orig;
    write_words();
    read_and_check("host");
  endtask

  task automatic bitrev_random();
    fill_random();
    write_words();
    run_op(1'b1, 3'd0);
    bitrev_model();
    read_and_check("bitrev");
  endtask

  task automatic bitrev_twice();
    fill_random();
    write_words();
    run_op(1'b1, 3'd0);
    run_op(1'b1, 3'd0);
    expect_mem = orig;
    read_and_check("bitrev twice");
  endtask

  task automatic transpose_each_base();
    for (int b = 0; b <= 4; b++) begin
      fill_random();
      write_words();
      run_op(1'b0, 3'(b));
      transpose_model(b);
      read_and_check($sformatf("transpose base %0d", b));
    end
  endtask

  task automatic busy_and_restart();
    fill_random();
    write_words();
    check_value("busy before start", 32'(1'b0), 32'(busy));
    start_bitrev = 1'b1;
    @(posedge clk);
    #1;
    start_bitrev = 1'b0;
    check_value("busy at start edge", 32'(1'b1), 32'(busy));
    repeat (10) begin
      @(posedge clk);
      #1;
      check_value("busy during run", 32'(1'b1), 32'(busy));
    end
    // a stray start while running must be ignored
    start_transpose = 1'b1;
    transpose_base = 3'd2;
    @(posedge clk);
    #1;
    start_transpose = 1'b0;
    check_value("busy after second start", 32'(1'b1), 32'(busy));
    wait_idle();
    repeat (3) begin
      @(posedge clk);
      #1;
      check_value("busy after end", 32'(1'b0), 32'(busy));
    end
    bitrev_model();
    read_and_check("restart");
  endtask

  initial begin
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    start_bitrev = 1'b0;
    start_transpose = 1'b0;
    transpose_base = '0;
    rng_state = 32'hfcd8_040b;
    wait (rstn === 1'b1);
    @(posedge clk);
    #1;
    host_write_readback();
    bitrev_random();
    bitrev_twice();
    transpose_each_base();
    busy_and_restart();
    $display("** PASS **");
    $finish;
  end

endmodule

/* project.f */
buffer_pkg.sv
perm_pkg.sv
ram_if.sv
beat_if.sv
buffer_ram.sv
load_sequencer.sv
transposer.sv
store_sequencer.sv
bitrev_transpose_top.sv
tb_clkgen.sv
tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator and run, exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module tb_top -f project.f
./obj_dir/Vtb_top
